/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_eth_pcs -Mdir obj_dir -o tb_eth_pcs
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_eth_pcs 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "TESTS PASSED"; then
    exit 0
else
    exit 1
fi

/* sim.f */
src/eth_pcs_pkg.sv
src/eth_pcs_tx_encoder.sv
src/eth_pcs_tx_line_pipe.sv
src/eth_pcs_rx_decoder.sv
src/eth_pcs_top.sv
testbench/tb_eth_pcs.sv

/* src/eth_pcs_pkg.sv */
// PCS block typedefs, LFSR widths and taps, scrambler, descrambler and PRBS31 step functions.
package eth_pcs_pkg;

    localparam int DATA_W = 64;
    localparam int HDR_W = 2;
    localparam int BLOCK_W = DATA_W + HDR_W;

    // Taps count bit times back from the bit being produced.
    localparam int SCR_TAP_A = 39;
    localparam int SCR_TAP_B = 58;
    localparam int SCR_W = SCR_TAP_B;
    localparam int PRBS_TAP_A = 28;
    localparam int PRBS_TAP_B = 31;
    localparam int PRBS_W = PRBS_TAP_B;

    typedef logic [DATA_W-1:0] pcs_data_t;
    typedef logic [HDR_W-1:0] pcs_hdr_t;
    typedef logic [SCR_W-1:0] scr_state_t;
    typedef logic [PRBS_W-1:0] prbs_state_t;
    typedef logic [15:0] err_count_t;

    // State bit 0 is the most recent line bit, bit k is k+1 bit times back.
    function automatic void scramble_64(
        input  pcs_data_t  din,
        input  scr_state_t state_in,
        output pcs_data_t  dout,
        output scr_state_t state_out
    );
        scr_state_t s;
        s = state_in;
        for (int i = 0; i < DATA_W; i++) begin
            dout[i] = din[i] ^ s[SCR_TAP_A-1] ^ s[SCR_TAP_B-1];
            s = {s[SCR_W-2:0], dout[i]};
        end
        state_out = s;
    endfunction

    // Feeds the received bits into the state, so it recovers after any error burst.
    function automatic void descramble_64(
        input  pcs_data_t  din,
        input  scr_state_t state_in,
        output pcs_data_t  dout,
        output scr_state_t state_out
    );
        scr_state_t s;
        s = state_in;
        for (int i = 0; i < DATA_W; i++) begin
            dout[i] = din[i] ^ s[SCR_TAP_A-1] ^ s[SCR_TAP_B-1];
            s = {s[SCR_W-2:0], din[i]};
        end
        state_out = s;
    endfunction

    function automatic void prbs31_next_66(
        input  prbs_state_t        state_in,
        output logic [BLOCK_W-1:0] bits,
        output prbs_state_t        state_out
    );
        prbs_state_t s;
        s = state_in;
        for (int i = 0; i < BLOCK_W; i++) begin
            bits[i] = s[PRBS_TAP_A-1] ^ s[PRBS_TAP_B-1];
            s = {s[PRBS_W-2:0], bits[i]};
        end
        state_out = s;
    endfunction

endpackage

/* src/eth_pcs_rx_decoder.sv */
// Receive stage with payload descrambler, PRBS31 checker and saturating block-error counter.
`timescale 1ns/1ps

module eth_pcs_rx_decoder (
    input  logic                    clk,
    input  logic                    reset,
    input  eth_pcs_pkg::pcs_data_t  serdes_rx_data,
    input  eth_pcs_pkg::pcs_hdr_t   serdes_rx_hdr,
    input  logic                    cfg_rx_prbs31_enable,
    output eth_pcs_pkg::pcs_data_t  rx_data,
    output eth_pcs_pkg::pcs_hdr_t   rx_hdr,
    output eth_pcs_pkg::err_count_t rx_prbs_err_count
);

    import eth_pcs_pkg::*;

    scr_state_t descr_state;
    scr_state_t descr_state_next;
    pcs_data_t descr_data;

    prbs_state_t chk_state;
    prbs_state_t chk_state_next;
    logic chk_mismatch;
    logic chk_warm;
    logic chk_err_flag;

    always_comb begin
        descramble_64(serdes_rx_data, descr_state, descr_data, descr_state_next);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            descr_state <= '1;
            rx_data <= '0;
            rx_hdr <= '0;
        end else begin
            descr_state <= descr_state_next;
            rx_data <= descr_data;
            rx_hdr <= serdes_rx_hdr;
        end
    end

    // Each bit is predicted from the 31 received bits before it.
    // The state is built from line bits, so no seed search is needed.
    always_comb begin : prbs_predict
        logic [BLOCK_W-1:0] rx_bits;
        prbs_state_t s;

        rx_bits = ~{serdes_rx_data, serdes_rx_hdr};
        s = chk_state;
        chk_mismatch = 1'b0;
        for (int i = 0; i < BLOCK_W; i++) begin
            if ((s[PRBS_TAP_A-1] ^ s[PRBS_TAP_B-1]) != rx_bits[i]) begin
                chk_mismatch = 1'b1;
            end
            s = {s[PRBS_W-2:0], rx_bits[i]};
        end
        chk_state_next = s;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            chk_state <= '1;
            chk_warm <= 1'b0;
            chk_err_flag <= 1'b0;
        end else begin
            if (cfg_rx_prbs31_enable) begin
                chk_state <= chk_state_next;
                chk_warm <= 1'b1;
            end else begin
                chk_warm <= 1'b0;
            end
            // First block after enable only seeds the predictor.
            chk_err_flag <= cfg_rx_prbs31_enable && chk_warm && chk_mismatch;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_prbs_err_count <= '0;
        end else if (chk_err_flag && (rx_prbs_err_count != '1)) begin
            rx_prbs_err_count <= rx_prbs_err_count + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        !reset |=> (rx_prbs_err_count >= $past(rx_prbs_err_count)))
    else $error("rx decoder: error count went down to %0d", rx_prbs_err_count);

endmodule

/* src/eth_pcs_top.sv */
// PCS top level with transmit encoder, line pipeline and receive decoder.
`timescale 1ns/1ps

module eth_pcs_top #(
    parameter int LINE_PIPE_DEPTH = 2
) (
    input  logic                    clk,
    input  logic                    reset,

    // Transmit block interface.
    input  eth_pcs_pkg::pcs_data_t  tx_data,
    input  eth_pcs_pkg::pcs_hdr_t   tx_hdr,
    input  logic                    cfg_tx_prbs31_enable,

    // SERDES transmit side.
    output eth_pcs_pkg::pcs_data_t  serdes_tx_data,
    output eth_pcs_pkg::pcs_hdr_t   serdes_tx_hdr,

    // SERDES receive side.
    input  eth_pcs_pkg::pcs_data_t  serdes_rx_data,
    input  eth_pcs_pkg::pcs_hdr_t   serdes_rx_hdr,
    input  logic                    cfg_rx_prbs31_enable,

    // Receive block interface and test-pattern status.
    output eth_pcs_pkg::pcs_data_t  rx_data,
    output eth_pcs_pkg::pcs_hdr_t   rx_hdr,
    output eth_pcs_pkg::err_count_t rx_prbs_err_count
);

    import eth_pcs_pkg::*;

    pcs_data_t enc_data;
    pcs_hdr_t enc_hdr;

    eth_pcs_tx_encoder u_tx_encoder (
        .clk                  (clk),
        .reset                (reset),
        .tx_data              (tx_data),
        .tx_hdr               (tx_hdr),
        .cfg_tx_prbs31_enable (cfg_tx_prbs31_enable),
        .enc_data             (enc_data),
        .enc_hdr              (enc_hdr)
    );

    // Extra register stages ease timing into the SERDES.
    eth_pcs_tx_line_pipe #(
        .LINE_PIPE_DEPTH (LINE_PIPE_DEPTH)
    ) u_tx_line_pipe (
        .clk      (clk),
        .reset    (reset),
        .in_data  (enc_data),
        .in_hdr   (enc_hdr),
        .out_data (serdes_tx_data),
        .out_hdr  (serdes_tx_hdr)
    );

    eth_pcs_rx_decoder u_rx_decoder (
        .clk                  (clk),
        .reset                (reset),
        .serdes_rx_data       (serdes_rx_data),
        .serdes_rx_hdr        (serdes_rx_hdr),
        .cfg_rx_prbs31_enable (cfg_rx_prbs31_enable),
        .rx_data              (rx_data),
        .rx_hdr               (rx_hdr),
        .rx_prbs_err_count    (rx_prbs_err_count)
    );

endmodule

/* src/eth_pcs_tx_encoder.sv */
// Transmit stage with payload scrambler, PRBS31 test-pattern generator and block register.
`timescale 1ns/1ps

module eth_pcs_tx_encoder (
    input  logic                   clk,
    input  logic                   reset,
    input  eth_pcs_pkg::pcs_data_t tx_data,
    input  eth_pcs_pkg::pcs_hdr_t  tx_hdr,
    input  logic                   cfg_tx_prbs31_enable,
    output eth_pcs_pkg::pcs_data_t enc_data,
    output eth_pcs_pkg::pcs_hdr_t  enc_hdr
);

    import eth_pcs_pkg::*;

    scr_state_t scr_state;
    scr_state_t scr_state_next;
    pcs_data_t scr_data;

    prbs_state_t prbs_state;
    prbs_state_t prbs_state_next;
    logic [BLOCK_W-1:0] prbs_bits;

    logic hdr_valid;

    always_comb begin
        scramble_64(tx_data, scr_state, scr_data, scr_state_next);
    end

    // 66 pattern bits per block, header first on the line.
    always_comb begin
        prbs31_next_66(prbs_state, prbs_bits, prbs_state_next);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            scr_state <= '1;
            prbs_state <= '1;
            enc_data <= '0;
            enc_hdr <= '0;
        end else if (cfg_tx_prbs31_enable) begin
            // Scrambler state holds while the test pattern is sent.
            prbs_state <= prbs_state_next;
            enc_data <= ~prbs_bits[BLOCK_W-1:HDR_W];
            enc_hdr <= ~prbs_bits[HDR_W-1:0];
        end else begin
            scr_state <= scr_state_next;
            enc_data <= scr_data;
            enc_hdr <= tx_hdr;
        end
    end

    // Data (01) and control (10) are the only legal sync headers.
    assign hdr_valid = (tx_hdr == 2'b01) || (tx_hdr == 2'b10);

    // A legal header taken in normal mode shows up legal on the next cycle.
    assert property (@(posedge clk) disable iff (reset)
        (!cfg_tx_prbs31_enable && hdr_valid) |=> (enc_hdr == 2'b01 || enc_hdr == 2'b10))
    else $error("tx encoder: illegal sync header %b after legal input", enc_hdr);

endmodule

/* src/eth_pcs_tx_line_pipe.sv */
// Register pipeline of configurable depth between the transmit encoder and the SERDES.
`timescale 1ns/1ps

module eth_pcs_tx_line_pipe #(
    parameter int LINE_PIPE_DEPTH = 2
) (
    input  logic                   clk,
    input  logic                   reset,
    input  eth_pcs_pkg::pcs_data_t in_data,
    input  eth_pcs_pkg::pcs_hdr_t  in_hdr,
    output eth_pcs_pkg::pcs_data_t out_data,
    output eth_pcs_pkg::pcs_hdr_t  out_hdr
);

    import eth_pcs_pkg::*;

    if (LINE_PIPE_DEPTH < 0 || LINE_PIPE_DEPTH > 4) begin : g_bad_depth
        $error("LINE_PIPE_DEPTH must be in the range 0 to 4");
    end

    if (LINE_PIPE_DEPTH == 0) begin : g_wire
        assign out_data = in_data;
        assign out_hdr = in_hdr;
    end else begin : g_regs
        // Bit n is set once stage n holds a block taken after reset.
        logic [LINE_PIPE_DEPTH-1:0] fill_q;

        for (genvar n = 0; n < LINE_PIPE_DEPTH; n++) begin : g_stage
            pcs_data_t data_d;
            pcs_hdr_t hdr_d;
            pcs_data_t data_q;
            pcs_hdr_t hdr_q;

            if (n == 0) begin : g_src
                assign data_d = in_data;
                assign hdr_d = in_hdr;
            end else begin : g_src
                assign data_d = g_stage[n-1].data_q;
                assign hdr_d = g_stage[n-1].hdr_q;
            end

            always_ff @(posedge clk) begin
                if (reset) begin
                    data_q <= '0;
                    hdr_q <= '0;
                end else begin
                    data_q <= data_d;
                    hdr_q <= hdr_d;
                end
            end
        end

        assign out_data = g_stage[LINE_PIPE_DEPTH-1].data_q;
        assign out_hdr = g_stage[LINE_PIPE_DEPTH-1].hdr_q;

        always_ff @(posedge clk) begin
            if (reset) begin
                fill_q <= '0;
            end else begin
                fill_q <= (fill_q << 1) | 1'b1;
            end
        end

        assert property (@(posedge clk) disable iff (reset)
            fill_q[LINE_PIPE_DEPTH-1] |-> (out_hdr == $past(in_hdr, LINE_PIPE_DEPTH)))
        else $error("line pipe: header out of step with input delayed by %0d",
                    LINE_PIPE_DEPTH);
    end

endmodule

/* testbench/tb_eth_pcs.sv */
// Testbench for the PCS top level with loopback channel, error injection and bit-serial models.
`timescale 1ns/1ps

module tb_eth_pcs;

    localparam int LINE_PIPE_DEPTH = 2;
    localparam int TIMEOUT_CYCLES = 1000;

    logic clk;
    logic reset;
    logic [63:0] tx_data;
    logic [1:0] tx_hdr;
    logic cfg_tx_prbs31_enable;
    logic [63:0] serdes_rx_data;
    logic [1:0] serdes_rx_hdr;
    logic cfg_rx_prbs31_enable;
    logic [63:0] serdes_tx_data;
    logic [1:0] serdes_tx_hdr;
    logic [63:0] rx_data;
    logic [1:0] rx_hdr;
    logic [15:0] rx_prbs_err_count;

    integer seed;
    logic [65:0] err_mask;

    // Model histories, index 0 is the oldest bit and the top index the newest.
    logic [57:0] scr_hist;
    logic [57:0] descr_hist;
    logic [30:0] gen_hist;
    logic [30:0] chk_hist;
    logic chk_warm;
    logic [15:0] model_count;
    int e2e_blocks;

    // Expected values, one entry per check cycle.
    logic [65:0] exp_tx_q[$];
    logic [65:0] exp_rx_q[$];
    logic [15:0] exp_count_q[$];
    logic [66:0] sent_q[$];

    eth_pcs_top #(
        .LINE_PIPE_DEPTH (LINE_PIPE_DEPTH)
    ) DUT (
        .clk                  (clk),
        .reset                (reset),
        .tx_data              (tx_data),
        .tx_hdr               (tx_hdr),
        .cfg_tx_prbs31_enable (cfg_tx_prbs31_enable),
        .serdes_tx_data       (serdes_tx_data),
        .serdes_tx_hdr        (serdes_tx_hdr),
        .serdes_rx_data       (serdes_rx_data),
        .serdes_rx_hdr        (serdes_rx_hdr),
        .cfg_rx_prbs31_enable (cfg_rx_prbs31_enable),
        .rx_data              (rx_data),
        .rx_hdr               (rx_hdr),
        .rx_prbs_err_count    (rx_prbs_err_count)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Taps sit 39 and 58 bits back in the transmitted stream.
    function automatic logic [63:0] scramble_model(input logic [63:0] din);
        logic [63:0] dout;
        for (int i = 0; i < 64; i++) begin
            dout[i] = din[i] ^ scr_hist[19] ^ scr_hist[0];
            scr_hist = {dout[i], scr_hist[57:1]};
        end
        return dout;
    endfunction

    function automatic logic [63:0] descramble_model(input logic [63:0] din);
        logic [63:0] dout;
        for (int i = 0; i < 64; i++) begin
            dout[i] = din[i] ^ descr_hist[19] ^ descr_hist[0];
            descr_hist = {din[i], descr_hist[57:1]};
        end
        return dout;
    endfunction

    // Raw PRBS31 bits, 28 and 31 bits back.
    function automatic logic [65:0] prbs_gen_model();
        logic [65:0] bits;
        for (int i = 0; i < 66; i++) begin
            bits[i] = gen_hist[3] ^ gen_hist[0];
            gen_hist = {bits[i], gen_hist[30:1]};
        end
        return bits;
    endfunction

    function automatic logic prbs_check_model(input logic [65:0] line_bits);
        logic [65:0] bits;
        logic bad;
        bits = ~line_bits;
        bad = 1'b0;
        for (int i = 0; i < 66; i++) begin
            if ((chk_hist[3] ^ chk_hist[0]) != bits[i]) begin
                bad = 1'b1;
            end
            chk_hist = {bits[i], chk_hist[30:1]};
        end
        return bad;
    endfunction

    task automatic fail_run(input string why);
        $display("Error at time %0t: %s", $time, why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "Simulation stopped at the first error.");
        end
    endtask

    task automatic check_outputs();
        logic [65:0] exp_tx;
        logic [65:0] exp_rx;
        logic [15:0] exp_count;
        logic [66:0] sent;
        exp_tx = exp_tx_q.pop_front();
        exp_rx = exp_rx_q.pop_front();
        exp_count = exp_count_q.pop_front();
        sent = sent_q.pop_front();
        check_value("serdes_tx_data", serdes_tx_data, exp_tx[65:2]);
        check_value("serdes_tx_hdr", {62'd0, serdes_tx_hdr}, {62'd0, exp_tx[1:0]});
        check_value("rx_data", rx_data, exp_rx[65:2]);
        check_value("rx_hdr", {62'd0, rx_hdr}, {62'd0, exp_rx[1:0]});
        check_value("rx_prbs_err_count", {48'd0, rx_prbs_err_count}, {48'd0, exp_count});
        // The descrambler needs two real blocks before its history is clean.
        if (sent[66]) begin
            e2e_blocks++;
            if (e2e_blocks > 2) begin
                check_value("rx_data end to end", rx_data, sent[65:2]);
                check_value("rx_hdr end to end", {62'd0, rx_hdr}, {62'd0, sent[1:0]});
            end
        end else begin
            e2e_blocks = 0;
        end
    endtask

    task automatic drive_inputs(input logic tx_prbs, input logic rx_prbs);
        logic [31:0] r;
        logic [63:0] data;
        logic [1:0] hdr;
        logic [65:0] line;
        logic bad;
        r = $random(seed);
        data[31:0] = r;
        r = $random(seed);
        data[63:32] = r;
        r = $random(seed);
        hdr = r[0] ? 2'b01 : 2'b10;
        tx_data = data;
        tx_hdr = hdr;
        cfg_tx_prbs31_enable = tx_prbs;
        cfg_rx_prbs31_enable = rx_prbs;
        if (tx_prbs) begin
            exp_tx_q.push_back(~prbs_gen_model());
            sent_q.push_back({1'b0, 66'd0});
        end else begin
            exp_tx_q.push_back({scramble_model(data), hdr});
            sent_q.push_back({1'b1, data, hdr});
        end

        // Loopback channel, header bits go first on the line.
        line = {serdes_tx_data, serdes_tx_hdr} ^ err_mask;
        serdes_rx_data = line[65:2];
        serdes_rx_hdr = line[1:0];
        exp_rx_q.push_back({descramble_model(line[65:2]), line[1:0]});
        if (rx_prbs) begin
            bad = prbs_check_model(line);
            if (bad && chk_warm && model_count != 16'hffff) begin
                model_count = model_count + 16'd1;
            end
            chk_warm = 1'b1;
        end else begin
            chk_warm = 1'b0;
        end
        exp_count_q.push_back(model_count);
        err_mask = '0;
    endtask

    task automatic run_cycle(input logic tx_prbs, input logic rx_prbs);
        @(posedge clk);
        #1;
        check_outputs();
        drive_inputs(tx_prbs, rx_prbs);
    endtask

    task automatic wait_line_active();
        int n;
        n = 0;
        while (serdes_tx_hdr == 2'b00 && n < TIMEOUT_CYCLES) begin
            run_cycle(1'b0, 1'b0);
            n++;
        end
        if (serdes_tx_hdr == 2'b00) begin
            fail_run("no block reached the line outputs after reset");
        end
    endtask

    task automatic wait_count_reaches(input logic [15:0] target);
        int n;
        n = 0;
        while (rx_prbs_err_count != target && n < TIMEOUT_CYCLES) begin
            run_cycle(1'b1, 1'b1);
            n++;
        end
        if (rx_prbs_err_count != target) begin
            fail_run("the error counter never reached the expected value");
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [15:0] held;
        int pos;
        seed = 3528;
        reset = 1'b1;
        tx_data = '0;
        tx_hdr = '0;
        cfg_tx_prbs31_enable = 1'b0;
        serdes_rx_data = '0;
        serdes_rx_hdr = '0;
        cfg_rx_prbs31_enable = 1'b0;
        err_mask = '0;
        scr_hist = '1;
        descr_hist = '1;
        gen_hist = '1;
        chk_hist = '1;
        chk_warm = 1'b0;
        model_count = '0;
        e2e_blocks = 0;
        // Pipeline registers come out of reset holding zero blocks.
        repeat (LINE_PIPE_DEPTH) exp_tx_q.push_back('0);
        repeat (LINE_PIPE_DEPTH + 1) sent_q.push_back('0);
        exp_count_q.push_back('0);

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        drive_inputs(1'b0, 1'b0);

        wait_line_active();
        repeat (2000) run_cycle(1'b0, 1'b0);
        assert (rx_prbs_err_count == 16'd0) else begin
            fail_run("error count moved while the PRBS31 checker was off");
        end

        // Pattern first, the checker is switched on once it is on the line.
        repeat (20) run_cycle(1'b1, 1'b0);
        repeat (500) run_cycle(1'b1, 1'b1);
        assert (rx_prbs_err_count == 16'd0) else begin
            fail_run("clean PRBS31 stream produced block errors");
        end

        for (int e = 0; e < 10; e++) begin
            r = $random(seed);
            pos = (e == 0) ? 0 : (e == 1) ? 65 : int'(r % 32'd66);
            err_mask = 66'd1 << pos;
            run_cycle(1'b1, 1'b1);
            wait_count_reaches(model_count);
            repeat (30) run_cycle(1'b1, 1'b1);
        end
        assert (rx_prbs_err_count >= 16'd10) else begin
            fail_run("fewer block errors counted than errors injected");
        end

        // Count holds with the checker off, even on a corrupted block.
        held = model_count;
        run_cycle(1'b1, 1'b0);
        err_mask = 66'd1 << 7;
        repeat (50) run_cycle(1'b1, 1'b0);
        check_value("rx_prbs_err_count", {48'd0, rx_prbs_err_count}, {48'd0, held});

        $display("TESTS PASSED");
        $finish;
    end

endmodule
